// File: hdl/rv_exec_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I execute slice shared types
// Opcodes, funct codes and ALU operation enum
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rv_exec_pkg;

    // Data word, fixed by the ISA
    typedef logic [31:0] xlen_t;

    // Register number, x0 to x31
    typedef logic [4:0] reg_addr_t;

    // Raw instruction word
    typedef logic [31:0] insn_t;

    // Major opcodes handled by the slice
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3 codes, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 codes
    // Zero for the base operation, 0x20 selects SUB or SRA
    localparam logic [6:0] F7_BASE = 7'h00;
    localparam logic [6:0] F7_ALT  = 7'h20;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        // Second operand straight through, used by LUI
        ALU_PASS_B
    } alu_op_e;

endpackage : rv_exec_pkg

// File: hdl/register_file.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file, 32 x 32 bits
// Two falling-edge read ports, one write port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module register_file
    import rv_exec_pkg::*;
#(
    // Reset value of x2, the stack pointer
    parameter xlen_t SP_INIT = 32'h0110_0000
) (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    input  reg_addr_t rd_addr_i,
    input  xlen_t     wr_data_i,
    input  logic      wr_en_i,
    output xlen_t     rs1_data_o,
    output xlen_t     rs2_data_o
);

    // Register storage
    xlen_t regs [32];

    // Read latches
    xlen_t rs1_q;
    xlen_t rs2_q;

    // Write port on the rising edge
    always_ff @(posedge clk) begin
        if (rst) begin
            // Clear all, then load the stack pointer
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
            regs[2] <= SP_INIT;
        end else if (wr_en_i && (rd_addr_i != '0)) begin
            // x0 is never written
            regs[rd_addr_i] <= wr_data_i;
        end
    end

    // Read ports latched half a cycle later
    // A write at one rising edge is seen by the next instruction
    always_ff @(negedge clk) begin
        if (rst) begin
            // Mirror the reset contents of the array
            rs1_q <= (rs1_addr_i == 5'd2) ? SP_INIT : '0;
            rs2_q <= (rs2_addr_i == 5'd2) ? SP_INIT : '0;
        end else begin
            // Address zero reads as zero
            rs1_q <= (rs1_addr_i != '0) ? regs[rs1_addr_i] : '0;
            rs2_q <= (rs2_addr_i != '0) ? regs[rs2_addr_i] : '0;
        end
    end

    assign rs1_data_o = rs1_q;
    assign rs2_data_o = rs2_q;

endmodule : register_file

// File: hdl/insn_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I decoder for OP, OP-IMM and LUI
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module insn_decoder
    import rv_exec_pkg::*;
(
    input  insn_t     insn_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    output reg_addr_t rd_addr_o,
    output xlen_t     imm_o,
    output logic      use_imm_o,
    output alu_op_e   alu_op_o,
    output logic      reg_write_o,
    output logic      illegal_o
);

    // Instruction fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;

    assign opcode = insn_i[6:0];
    assign funct3 = insn_i[14:12];
    assign funct7 = insn_i[31:25];

    // Register fields sit at fixed positions in every format
    assign rs1_addr_o = insn_i[19:15];
    assign rs2_addr_o = insn_i[24:20];
    assign rd_addr_o  = insn_i[11:7];

    always_comb begin
        // Defaults, an unknown encoding stays illegal
        imm_o     = '0;
        use_imm_o = 1'b0;
        alu_op_o  = ALU_ADD;
        legal     = 1'b0;

        case (opcode)
            OPC_OP: begin
                // Register-register, funct7 must be zero or the alternate code
                case (funct3)
                    F3_ADD_SUB: begin
                        if (funct7 == F7_BASE) begin
                            alu_op_o = ALU_ADD;
                            legal    = 1'b1;
                        end else if (funct7 == F7_ALT) begin
                            alu_op_o = ALU_SUB;
                            legal    = 1'b1;
                        end
                    end
                    F3_SRL_SRA: begin
                        if (funct7 == F7_BASE) begin
                            alu_op_o = ALU_SRL;
                            legal    = 1'b1;
                        end else if (funct7 == F7_ALT) begin
                            alu_op_o = ALU_SRA;
                            legal    = 1'b1;
                        end
                    end
                    F3_SLL:  alu_op_o = ALU_SLL;
                    F3_SLT:  alu_op_o = ALU_SLT;
                    F3_SLTU: alu_op_o = ALU_SLTU;
                    F3_XOR:  alu_op_o = ALU_XOR;
                    F3_OR:   alu_op_o = ALU_OR;
                    default: alu_op_o = ALU_AND;
                endcase
                // Remaining funct3 codes only accept funct7 of zero
                if (funct3 != F3_ADD_SUB && funct3 != F3_SRL_SRA) begin
                    legal = (funct7 == F7_BASE);
                end
            end

            OPC_OP_IMM: begin
                // Sign-extended I-type immediate
                imm_o     = {{20{insn_i[31]}}, insn_i[31:20]};
                use_imm_o = 1'b1;
                legal     = 1'b1;
                case (funct3)
                    F3_ADD_SUB: alu_op_o = ALU_ADD;
                    F3_SLT:     alu_op_o = ALU_SLT;
                    F3_SLTU:    alu_op_o = ALU_SLTU;
                    F3_XOR:     alu_op_o = ALU_XOR;
                    F3_OR:      alu_op_o = ALU_OR;
                    F3_AND:     alu_op_o = ALU_AND;
                    F3_SLL: begin
                        // shamt in bits 24:20, upper bits must be zero
                        alu_op_o = ALU_SLL;
                        legal    = (funct7 == F7_BASE);
                    end
                    default: begin
                        // SRLI or SRAI by funct7
                        alu_op_o = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                        legal    = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                    end
                endcase
            end

            OPC_LUI: begin
                // Upper immediate, low 12 bits zero
                imm_o     = {insn_i[31:12], 12'b0};
                use_imm_o = 1'b1;
                alu_op_o  = ALU_PASS_B;
                legal     = 1'b1;
            end

            default: legal = 1'b0;
        endcase

        // Writes to x0 are dropped here
        illegal_o   = ~legal;
        reg_write_o = legal && (rd_addr_o != '0);
    end

endmodule : insn_decoder

// File: hdl/int_alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational RV32I integer ALU
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module int_alu
    import rv_exec_pkg::*;
(
    input  xlen_t   a_i,
    input  xlen_t   b_i,
    input  alu_op_e op_i,
    output xlen_t   result_o
);

    // Shift amount from the low 5 bits of the second operand
    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD: begin
                result_o = a_i + b_i;
            end
            ALU_SUB: begin
                result_o = a_i - b_i;
            end
            ALU_SLL: begin
                result_o = a_i << shamt;
            end
            ALU_SLT: begin
                // Signed compare
                result_o = ($signed(a_i) < $signed(b_i)) ? 32'd1 : 32'd0;
            end
            ALU_SLTU: begin
                // Unsigned compare
                result_o = (a_i < b_i) ? 32'd1 : 32'd0;
            end
            ALU_XOR: begin
                result_o = a_i ^ b_i;
            end
            ALU_SRL: begin
                // Zero fill
                result_o = a_i >> shamt;
            end
            ALU_SRA: begin
                // Sign fill
                result_o = xlen_t'($signed(a_i) >>> shamt);
            end
            ALU_OR: begin
                result_o = a_i | b_i;
            end
            ALU_AND: begin
                result_o = a_i & b_i;
            end
            ALU_PASS_B: begin
                // LUI path, immediate goes straight out
                result_o = b_i;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule : int_alu

// File: hdl/exec_slice.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer execute slice, top level
// Decode, register read, ALU and write-back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module exec_slice
    import rv_exec_pkg::*;
#(
    parameter xlen_t SP_INIT = 32'h0110_0000
) (
    input  logic      clk,
    input  logic      rst,
    input  insn_t     insn_i,
    input  logic      valid_i,
    output logic      wb_we_o,
    output reg_addr_t wb_rd_o,
    output xlen_t     wb_data_o,
    output logic      illegal_o
);

    // Decoder outputs
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    xlen_t     imm;
    logic      use_imm;
    alu_op_e   alu_op;
    logic      reg_write;
    logic      dec_illegal;

    // Datapath
    xlen_t rs1_data;
    xlen_t rs2_data;
    xlen_t op_b;
    xlen_t alu_result;

    insn_decoder u_decoder (
        .insn_i      (insn_i),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .rd_addr_o   (rd_addr),
        .imm_o       (imm),
        .use_imm_o   (use_imm),
        .alu_op_o    (alu_op),
        .reg_write_o (reg_write),
        .illegal_o   (dec_illegal)
    );

    // Reads latch on the falling edge, write lands at the next rising edge
    register_file #(
        .SP_INIT (SP_INIT)
    ) u_regfile (
        .clk        (clk),
        .rst        (rst),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rd_addr_i  (rd_addr),
        .wr_data_i  (alu_result),
        .wr_en_i    (wb_we_o),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    // Immediate or rs2 as second operand
    assign op_b = use_imm ? imm : rs2_data;

    int_alu u_alu (
        .a_i      (rs1_data),
        .b_i      (op_b),
        .op_i     (alu_op),
        .result_o (alu_result)
    );

    // Write-back only for a valid, legal instruction outside reset
    assign wb_we_o   = valid_i && reg_write && !dec_illegal && !rst;
    assign wb_rd_o   = rd_addr;
    assign wb_data_o = alu_result;

    // Illegal flag only counts with valid_i
    assign illegal_o = valid_i && dec_illegal && !rst;

endmodule : exec_slice

// File: bench/exec_slice_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write-back and illegal flag checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module exec_slice_assertions
    import rv_exec_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      valid_i,
    input logic      wb_we_o,
    input reg_addr_t wb_rd_o,
    input logic      illegal_o
);

    // x0 never gets a write enable
    no_x0_write: assert property (@(posedge clk) wb_we_o |-> (wb_rd_o != '0))
        else $error("write enable with rd of zero");

    // An illegal instruction never writes
    no_illegal_write: assert property (@(posedge clk) !(wb_we_o && illegal_o))
        else $error("write enable together with illegal flag");

    // Both outputs need valid_i
    needs_valid: assert property (@(posedge clk) (wb_we_o || illegal_o) |-> valid_i)
        else $error("write enable or illegal flag without valid_i");

    quiet_in_reset: assert property (@(posedge clk) rst |-> (!wb_we_o && !illegal_o))
        else $error("write enable or illegal flag during reset");

endmodule : exec_slice_assertions

bind exec_slice exec_slice_assertions u_assertions (
    .clk       (clk),
    .rst       (rst),
    .valid_i   (valid_i),
    .wb_we_o   (wb_we_o),
    .wb_rd_o   (wb_rd_o),
    .illegal_o (illegal_o)
);

// File: bench/exec_slice_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the execute slice
// Applies a table of instructions and checks write-back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module exec_slice_tb
    import rv_exec_pkg::*;
();

    localparam int PERIOD = 100;
    localparam xlen_t SP = 32'h0110_0000;

    logic      clk;
    logic      rst;
    insn_t     insn_i;
    logic      valid_i;
    logic      wb_we_o;
    reg_addr_t wb_rd_o;
    xlen_t     wb_data_o;
    logic      illegal_o;

    // One row per cycle with expected values from the RV32I rules
    typedef struct packed {
        insn_t     insn;
        logic      valid;
        logic      we;
        reg_addr_t rd;
        xlen_t     data;
        logic      ill;
    } row_t;

    row_t rows[$];
    int   errors = 0;

    exec_slice dut0 (
        .clk       (clk),
        .rst       (rst),
        .insn_i    (insn_i),
        .valid_i   (valid_i),
        .wb_we_o   (wb_we_o),
        .wb_rd_o   (wb_rd_o),
        .wb_data_o (wb_data_o),
        .illegal_o (illegal_o)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Instruction encoders for R, I and U formats
    function automatic insn_t reg_op(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic insn_t imm_op(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                     reg_addr_t rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic insn_t lui_op(logic [19:0] imm, reg_addr_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    task automatic add_row(insn_t insn, logic valid, logic we, reg_addr_t rd, xlen_t data,
                           logic ill);
        row_t r;
        r.insn  = insn;
        r.valid = valid;
        r.we    = we;
        r.rd    = rd;
        r.data  = data;
        r.ill   = ill;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // Reset contents with x2 holding the stack pointer
        add_row(imm_op(12'h000, 5'd2, 3'd0, 5'd5), 1, 1, 5'd5, SP, 0);
        // x7 stays zero although reset saw a valid write to it
        add_row(imm_op(12'h000, 5'd7, 3'd0, 5'd6), 1, 1, 5'd6, 32'h0, 0);
        // Operands x1 = -5 and x3 = 3
        add_row(imm_op(12'hffb, 5'd0, 3'd0, 5'd1), 1, 1, 5'd1, 32'hffff_fffb, 0);
        add_row(imm_op(12'h003, 5'd0, 3'd0, 5'd3), 1, 1, 5'd3, 32'h3, 0);
        // Register-register ops where x7 becomes 8
        add_row(reg_op(7'h00, 5'd3, 5'd1, 3'd0, 5'd4), 1, 1, 5'd4, 32'hffff_fffe, 0);
        add_row(reg_op(7'h20, 5'd1, 5'd3, 3'd0, 5'd7), 1, 1, 5'd7, 32'h8, 0);
        add_row(reg_op(7'h00, 5'd3, 5'd3, 3'd1, 5'd8), 1, 1, 5'd8, 32'h18, 0);
        add_row(reg_op(7'h00, 5'd3, 5'd1, 3'd2, 5'd9), 1, 1, 5'd9, 32'h1, 0);
        add_row(reg_op(7'h00, 5'd3, 5'd1, 3'd3, 5'd10), 1, 1, 5'd10, 32'h0, 0);
        add_row(reg_op(7'h00, 5'd3, 5'd1, 3'd4, 5'd11), 1, 1, 5'd11, 32'hffff_fff8, 0);
        add_row(reg_op(7'h00, 5'd3, 5'd1, 3'd5, 5'd12), 1, 1, 5'd12, 32'h1fff_ffff, 0);
        add_row(reg_op(7'h20, 5'd3, 5'd1, 3'd5, 5'd13), 1, 1, 5'd13, 32'hffff_ffff, 0);
        add_row(reg_op(7'h00, 5'd7, 5'd3, 3'd6, 5'd14), 1, 1, 5'd14, 32'hb, 0);
        add_row(reg_op(7'h00, 5'd7, 5'd1, 3'd7, 5'd15), 1, 1, 5'd15, 32'h8, 0);
        // Register-immediate
        add_row(imm_op(12'hffc, 5'd1, 3'd2, 5'd16), 1, 1, 5'd16, 32'h1, 0);
        add_row(imm_op(12'hfff, 5'd3, 3'd3, 5'd17), 1, 1, 5'd17, 32'h1, 0);
        add_row(imm_op(12'h7ff, 5'd3, 3'd4, 5'd18), 1, 1, 5'd18, 32'h7fc, 0);
        add_row(imm_op(12'hff0, 5'd3, 3'd6, 5'd19), 1, 1, 5'd19, 32'hffff_fff3, 0);
        add_row(imm_op(12'h0f0, 5'd1, 3'd7, 5'd20), 1, 1, 5'd20, 32'hf0, 0);
        add_row(imm_op(12'h004, 5'd3, 3'd1, 5'd21), 1, 1, 5'd21, 32'h30, 0);
        add_row(imm_op(12'h01c, 5'd1, 3'd5, 5'd22), 1, 1, 5'd22, 32'hf, 0);
        add_row(imm_op(12'h401, 5'd1, 3'd5, 5'd23), 1, 1, 5'd23, 32'hffff_fffd, 0);
        // Dependent chain on x24 with no bubble
        add_row(imm_op(12'h064, 5'd0, 3'd0, 5'd24), 1, 1, 5'd24, 32'h64, 0);
        add_row(imm_op(12'h001, 5'd24, 3'd0, 5'd24), 1, 1, 5'd24, 32'h65, 0);
        add_row(imm_op(12'h001, 5'd24, 3'd0, 5'd24), 1, 1, 5'd24, 32'h66, 0);
        add_row(reg_op(7'h00, 5'd24, 5'd24, 3'd0, 5'd25), 1, 1, 5'd25, 32'hcc, 0);
        // Write to x0 is dropped and x0 still reads zero
        add_row(imm_op(12'h007, 5'd3, 3'd0, 5'd0), 1, 0, 5'd0, 32'h0, 0);
        add_row(reg_op(7'h00, 5'd3, 5'd0, 3'd0, 5'd26), 1, 1, 5'd26, 32'h3, 0);
        add_row(lui_op(20'habcde, 5'd27), 1, 1, 5'd27, 32'habcd_e000, 0);
        // Not valid so x3 keeps 3
        add_row(imm_op(12'h063, 5'd0, 3'd0, 5'd3), 0, 0, 5'd3, 32'h0, 0);
        add_row(imm_op(12'h000, 5'd3, 3'd0, 5'd29), 1, 1, 5'd29, 32'h3, 0);
        // Load opcode, MUL and SLLI with funct7 0x20 are all unsupported
        add_row({12'h000, 5'd0, 3'd2, 5'd3, 7'b0000011}, 1, 0, 5'd3, 32'h0, 1);
        add_row(reg_op(7'h01, 5'd3, 5'd1, 3'd0, 5'd3), 1, 0, 5'd3, 32'h0, 1);
        add_row(imm_op(12'h403, 5'd1, 3'd1, 5'd3), 1, 0, 5'd3, 32'h0, 1);
        add_row({12'h000, 5'd0, 3'd2, 5'd3, 7'b0000011}, 0, 0, 5'd3, 32'h0, 0);
        add_row(reg_op(7'h00, 5'd0, 5'd3, 3'd0, 5'd30), 1, 1, 5'd30, 32'h3, 0);
    endtask

    task automatic word_check(string name, xlen_t exp, xlen_t act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic addr_check(string name, reg_addr_t exp, reg_addr_t act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic bit_check(string name, logic exp, logic act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    initial begin
        rst     = 1'b1;
        valid_i = 1'b0;
        insn_i  = '0;
        build_table();
        // Valid instructions during reset neither write nor flag
        for (int c = 0; c < 9; c++) begin
            @(posedge clk);
            valid_i <= 1'b1;
            if (c < 5) begin
                insn_i <= imm_op(12'h005, 5'd0, 3'd0, 5'd7);
            end else begin
                insn_i <= {12'h000, 5'd0, 3'd2, 5'd3, 7'b0000011};
            end
            #(PERIOD - 10);
            bit_check($sformatf("reset cycle %0d wb_we_o", c), 1'b0, wb_we_o);
            bit_check($sformatf("reset cycle %0d illegal_o", c), 1'b0, illegal_o);
        end
        @(posedge clk);
        rst     <= 1'b0;
        valid_i <= 1'b0;
        foreach (rows[i]) begin
            @(posedge clk);
            insn_i  <= rows[i].insn;
            valid_i <= rows[i].valid;
            // Sample just before the edge that performs the write
            #(PERIOD - 10);
            bit_check($sformatf("row %0d wb_we_o", i), rows[i].we, wb_we_o);
            bit_check($sformatf("row %0d illegal_o", i), rows[i].ill, illegal_o);
            // Address and data only mean something with a write
            if (rows[i].we) begin
                addr_check($sformatf("row %0d wb_rd_o", i), rows[i].rd, wb_rd_o);
                word_check($sformatf("row %0d wb_data_o", i), rows[i].data, wb_data_o);
            end
        end
        $display("Rows: %0d, errors: %0d", rows.size(), errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog over the table length plus margin for reset
    initial begin
        #1;
        #((rows.size() + 20) * PERIOD);
        $display("Timeout: run did not complete within %0d cycles", rows.size() + 20);
        $display("Testbench failed");
        $finish;
    end

endmodule : exec_slice_tb

// File: tb.f
hdl/rv_exec_pkg.sv
hdl/register_file.sv
hdl/insn_decoder.sv
hdl/int_alu.sv
hdl/exec_slice.sv
bench/exec_slice_assertions.sv
bench/exec_slice_tb.sv
